// File: Makefile
VERILATOR ?= verilator
FLIST ?= all.f
TB_TOP ?= evb_tb
RTL_TOP ?= evb_top
OBJ_DIR ?= obj_dir
SIM_BIN ?= evb_sim
VFLAGS ?= --timing

SRCS := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)

sim: $(OBJ_DIR)/$(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/evb_pkg.sv
source/lane_if.sv
source/sync_fifo.sv
source/lane_rx.sv
source/ring_arbiter.sv
source/host_regs.sv
source/evb_top.sv
bench/evb_tb.sv

// File: bench/evb_input.txt
// One 32-bit hex value per line, parameters and expected register values first,
// then the idle beats as {4'h0, csr_en[3:0], 4'h0, k[3:0], word[15:0]}
000001a5  // CSR write with the clear bit set
000000a5  // CSR readback, clear bit reads zero
00000030  // Beats in the ordering test
00000028  // Words sent to lane 0 in the fill test
0000c000  // First fill word, later ones count up
00000010  // Ring status once full
80000004  // Lane 0 status after the fill, overflow and a full FIFO
0000010f  // CSR write that clears the overflow flags
0000000f  // CSR readback after the clear
00000004  // Lane 0 status after the clear, count only
00000006  // Number of idle beats below
00009a5c  // All lanes disabled
0000ffff
0f0fbc3c  // All lanes enabled, K on every lane
0f0f3c3c
0a0a5555  // Lanes 1 and 3 enabled with K, lanes 0 and 2 disabled
0505f7f7  // Lanes 0 and 2 enabled with K, lanes 1 and 3 disabled

// File: bench/evb_tb.sv
`timescale 1ns/10ps

module evb_tb;
	import evb_pkg::*;

	localparam int LANE_DEPTH = 4;
	localparam int RING_DEPTH = 16;
	localparam string STIM_FILE = "bench/evb_input.txt";
	localparam int STIM_LEN = 17;
	localparam logic [31:0] LFSR_SEED = 32'h6122_bb9a;

	// Word positions in the data file
	localparam int IDX_CSR_WR = 0;
	localparam int IDX_CSR_EXP = 1;
	localparam int IDX_ORDER = 2;
	localparam int IDX_FILL = 3;
	localparam int IDX_FILL_FIRST = 4;
	localparam int IDX_RING_FULL = 5;
	localparam int IDX_LANE_OVF = 6;
	localparam int IDX_CLR_WR = 7;
	localparam int IDX_CLR_CSR = 8;
	localparam int IDX_CLR_LANE = 9;
	localparam int IDX_IDLE_CNT = 10;
	localparam int IDX_IDLE_BEAT = 11;

	logic CLK125;
	logic rst;
	lane_word_t [NUM_LANES-1:0] link_data;
	logic [NUM_LANES-1:0] link_k;
	logic bus_sel;
	logic bus_we;
	bus_addr_t bus_addr;
	bus_data_t bus_wdata;
	bus_data_t bus_rdata;
	logic bus_ack;

	bus_data_t stim_mem [STIM_LEN];
	lane_word_t exp_q [NUM_LANES][$];
	logic [31:0] lfsr_state;
	int timeout_limit = 0;
	int cycle_count = 0;

	evb_top #(
		.LANE_DEPTH (LANE_DEPTH),
		.RING_DEPTH (RING_DEPTH)
	) DUT (
		.CLK125 (CLK125),
		.rst_i (rst),
		.link_data_i (link_data),
		.link_k_i (link_k),
		.bus_sel_i (bus_sel),
		.bus_we_i (bus_we),
		.bus_addr_i (bus_addr),
		.bus_wdata_i (bus_wdata),
		.bus_rdata_o (bus_rdata),
		.bus_ack_o (bus_ack)
	);

	initial begin
		CLK125 = 1'b0;
		forever #2 CLK125 = ~CLK125;
	end

	// Limit is set once the data file is read
	initial begin
		while (timeout_limit == 0 || cycle_count < timeout_limit) begin
			@(posedge CLK125);
			cycle_count++;
		end
		abort_run($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycle_count));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_data(input string what, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] bus_rdata_o (%s): got 0x%08h expected 0x%08h",
				what, got, exp));
		end
	endtask

	task automatic check_lane(input string what, input lane_idx_t got, input lane_idx_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] bus_rdata_o[17:16] (%s): got 0x%0h expected 0x%0h",
				what, got, exp));
		end
	endtask

	task automatic check_ack(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] bus_ack_o (%s): got 0x%0h expected 0x%0h",
				what, got, exp));
		end
	endtask

	//////////////////////////////
	// Random words
	//////////////////////////////
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[31]};
			lfsr_state = next_lfsr(lfsr_state);
		end
	endtask

	//////////////////////////////
	// Host bus
	//////////////////////////////
	task automatic bus_access(input logic we, input bus_addr_t addr, input bus_data_t wdata,
		output bus_data_t rdata);
		@(negedge CLK125);
		bus_sel = 1'b1;
		bus_we = we;
		bus_addr = addr;
		bus_wdata = wdata;
		@(negedge CLK125);
		bus_sel = 1'b0;
		bus_we = 1'b0;
		// Acknowledge and read data follow the strobe by one edge
		check_ack("strobe response", bus_ack, 1'b1);
		rdata = bus_rdata;
		@(negedge CLK125);
		check_ack("one cycle pulse", bus_ack, 1'b0);
	endtask

	task automatic reg_write(input bus_addr_t addr, input bus_data_t data);
		bus_data_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic reg_read(input bus_addr_t addr, output bus_data_t data);
		bus_access(1'b0, addr, '0, data);
	endtask

	task automatic expect_reg(input bus_addr_t addr, input bus_data_t exp, input string what);
		bus_data_t got;
		reg_read(addr, got);
		check_data(what, got, exp);
	endtask

	//////////////////////////////
	// Link side and scoreboard
	//////////////////////////////
	task automatic drive_beat(input lane_word_t [NUM_LANES-1:0] words,
		input logic [NUM_LANES-1:0] kflags);
		@(negedge CLK125);
		link_data = words;
		link_k = kflags;
		@(negedge CLK125);
		link_k = '1;
	endtask

	// One word per lane with roughly a quarter of them K-chars
	task automatic order_beat();
		lane_word_t [NUM_LANES-1:0] words;
		logic [NUM_LANES-1:0] kflags;
		logic [15:0] bits;
		for (int i = 0; i < NUM_LANES; i++) begin
			rand_bits(16, bits);
			words[i] = bits;
			rand_bits(2, bits);
			kflags[i] = &bits[1:0];
			if (!kflags[i]) begin
				exp_q[i].push_back(words[i]);
			end
		end
		drive_beat(words, kflags);
	endtask

	function automatic int pending_words();
		int n;
		n = 0;
		for (int i = 0; i < NUM_LANES; i++) begin
			n += exp_q[i].size();
		end
		return n;
	endfunction

	// Match against the head of each lane queue, so order per lane is enforced
	task automatic take_ring_word();
		bus_data_t rd;
		lane_idx_t tag;
		lane_word_t word;
		int src;
		reg_read(REG_RING_DATA, rd);
		if (!rd[31]) begin
			check_data("empty ring data", rd, '0);
		end else begin
			tag = rd[17:16];
			word = rd[15:0];
			src = -1;
			if (exp_q[tag].size() > 0 && exp_q[tag][0] == word) begin
				src = int'(tag);
			end
			for (int i = 0; i < NUM_LANES; i++) begin
				if (src < 0 && exp_q[i].size() > 0 && exp_q[i][0] == word) begin
					src = i;
				end
			end
			if (src < 0) begin
				abort_run($sformatf("Ring word 0x%04h is not the next word of any lane", word));
			end else begin
				check_lane("ring tag", tag, lane_idx_t'(src));
				check_data("ring data", rd, {1'b1, 13'b0, lane_idx_t'(src), exp_q[src][0]});
				void'(exp_q[src].pop_front());
			end
		end
	endtask

	task automatic expect_idle_lanes();
		for (int i = 0; i < NUM_LANES; i++) begin
			expect_reg(bus_addr_t'(int'(REG_LANE0) + i), '0, $sformatf("lane %0d status", i));
		end
		expect_reg(REG_RING_STAT, '0, "ring status");
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		bus_data_t beat;
		int n_idle;
		int n_order;
		int n_fill;
		lane_word_t fill_first;
		rst = 1'b1;
		link_data = '0;
		link_k = '1;
		bus_sel = 1'b0;
		bus_we = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		lfsr_state = LFSR_SEED;
		$readmemh(STIM_FILE, stim_mem);
		n_idle = int'(stim_mem[IDX_IDLE_CNT]);
		n_order = int'(stim_mem[IDX_ORDER]);
		n_fill = int'(stim_mem[IDX_FILL]);
		fill_first = stim_mem[IDX_FILL_FIRST][15:0];
		if (n_order == 0 || n_idle > STIM_LEN - IDX_IDLE_BEAT) begin
			abort_run("The data file is missing or its layout is wrong");
		end
		timeout_limit = 40 * (4 * n_idle + 4 * n_order + n_fill) + 2000;
		repeat (16) @(posedge CLK125);
		@(negedge CLK125);
		rst = 1'b0;

		// Reset values
		check_ack("after reset", bus_ack, 1'b0);
		expect_reg(REG_CSR, '0, "CSR");
		expect_idle_lanes();
		expect_reg(REG_RING_DATA, '0, "ring data");
		reg_write(REG_CSR, stim_mem[IDX_CSR_WR]);
		expect_reg(REG_CSR, stim_mem[IDX_CSR_EXP], "CSR");

		// Disabled lanes and K-chars push nothing
		for (int i = 0; i < n_idle; i++) begin
			beat = stim_mem[IDX_IDLE_BEAT + i];
			reg_write(REG_CSR, bus_data_t'(beat[27:24]) << CSR_EN_LSB);
			drive_beat({NUM_LANES{beat[15:0]}}, beat[19:16]);
		end
		expect_idle_lanes();

		// All lanes at once with the ring drained as it goes
		reg_write(REG_CSR, bus_data_t'((1 << NUM_LANES) - 1) << CSR_EN_LSB);
		for (int b = 0; b < n_order; b++) begin
			order_beat();
			repeat (4) take_ring_word();
		end
		while (pending_words() > 0) begin
			take_ring_word();
		end
		expect_reg(REG_RING_DATA, '0, "ring data");
		expect_idle_lanes();

		// Lane 0 flood with nobody reading the ring
		for (int i = 0; i < n_fill; i++) begin
			@(negedge CLK125);
			link_data[0] = fill_first + lane_word_t'(i);
			link_k = {{(NUM_LANES - 1){1'b1}}, 1'b0};
			if (i < RING_DEPTH + LANE_DEPTH) begin
				exp_q[0].push_back(link_data[0]);
			end
		end
		@(negedge CLK125);
		link_k = '1;
		expect_reg(REG_RING_STAT, stim_mem[IDX_RING_FULL], "ring status");
		expect_reg(REG_LANE0, stim_mem[IDX_LANE_OVF], "lane 0 status");

		// Overflow clear leaves the count alone
		reg_write(REG_CSR, stim_mem[IDX_CLR_WR]);
		expect_reg(REG_CSR, stim_mem[IDX_CLR_CSR], "CSR");
		expect_reg(REG_LANE0, stim_mem[IDX_CLR_LANE], "lane 0 status");
		while (pending_words() > 0) begin
			take_ring_word();
		end
		expect_reg(REG_RING_DATA, '0, "ring data");
		expect_idle_lanes();

		$display("** PASS **");
		$finish;
	end

endmodule

// File: source/evb_pkg.sv
package evb_pkg;

	// Link side
	localparam int NUM_LANES = 4;

	typedef logic [15:0] lane_word_t;
	typedef logic [1:0] lane_idx_t;
	typedef logic [15:0] count_t;

	// One ring slot, source lane on top
	typedef struct packed {
		lane_idx_t tag;
		lane_word_t word;
	} ring_entry_t;

	// Host register bus
	typedef logic [2:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	typedef enum bus_addr_t {
		REG_CSR = 3'd0,
		REG_LANE0 = 3'd1,
		REG_LANE1 = 3'd2,
		REG_LANE2 = 3'd3,
		REG_LANE3 = 3'd4,
		REG_RING_STAT = 3'd5,
		REG_RING_DATA = 3'd6
	} reg_addr_e;

	// CSR fields
	localparam int CSR_EN_LSB = 0;
	localparam int CSR_CLR_BIT = 8;

endpackage

// File: source/evb_top.sv
`timescale 1ns/10ps

module evb_top #(
	parameter int LANE_DEPTH = 4,
	parameter int RING_DEPTH = 16
) (
	input logic CLK125,
	input logic rst_i,
	input evb_pkg::lane_word_t [evb_pkg::NUM_LANES-1:0] link_data_i,
	input logic [evb_pkg::NUM_LANES-1:0] link_k_i,
	input logic bus_sel_i,
	input logic bus_we_i,
	input evb_pkg::bus_addr_t bus_addr_i,
	input evb_pkg::bus_data_t bus_wdata_i,
	output evb_pkg::bus_data_t bus_rdata_o,
	output logic bus_ack_o
);
	import evb_pkg::*;

	lane_if lane_bus [NUM_LANES] ();

	logic [NUM_LANES-1:0] lane_en;
	logic ovf_clr;
	logic ring_push;
	logic ring_pop;
	logic ring_full;
	logic ring_empty;
	ring_entry_t ring_entry;
	ring_entry_t ring_head;
	count_t ring_count;

	//////////////////////////////
	// Link lanes
	//////////////////////////////
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_rx
		lane_rx #(
			.LANE_DEPTH (LANE_DEPTH)
		) u_lane_rx (
			.CLK125 (CLK125),
			.rst_i (rst_i),
			.link_data_i (link_data_i[i]),
			.link_k_i (link_k_i[i]),
			.lane_en_i (lane_en[i]),
			.ovf_clr_i (ovf_clr),
			.lane (lane_bus[i])
		);
	end

	// Lanes into the shared ring
	ring_arbiter u_arbiter (
		.CLK125 (CLK125),
		.rst_i (rst_i),
		.lanes (lane_bus),
		.ring_full_i (ring_full),
		.ring_push_o (ring_push),
		.ring_entry_o (ring_entry)
	);

	sync_fifo #(
		.T (ring_entry_t),
		.DEPTH (RING_DEPTH)
	) ring_fifo (
		.CLK125 (CLK125),
		.rst_i (rst_i),
		.push_i (ring_push),
		.push_data_i (ring_entry),
		.pop_i (ring_pop),
		.head_o (ring_head),
		.empty_o (ring_empty),
		.full_o (ring_full),
		.count_o (ring_count)
	);

	//////////////////////////////
	// Host side
	//////////////////////////////
	host_regs u_regs (
		.CLK125 (CLK125),
		.rst_i (rst_i),
		.bus_sel_i (bus_sel_i),
		.bus_we_i (bus_we_i),
		.bus_addr_i (bus_addr_i),
		.bus_wdata_i (bus_wdata_i),
		.bus_rdata_o (bus_rdata_o),
		.bus_ack_o (bus_ack_o),
		.lanes (lane_bus),
		.ring_head_i (ring_head),
		.ring_empty_i (ring_empty),
		.ring_count_i (ring_count),
		.ring_pop_o (ring_pop),
		.lane_en_o (lane_en),
		.ovf_clr_o (ovf_clr)
	);

endmodule

// File: source/host_regs.sv
`timescale 1ns/10ps

module host_regs (
	input logic CLK125,
	input logic rst_i,
	input logic bus_sel_i,
	input logic bus_we_i,
	input evb_pkg::bus_addr_t bus_addr_i,
	input evb_pkg::bus_data_t bus_wdata_i,
	output evb_pkg::bus_data_t bus_rdata_o,
	output logic bus_ack_o,
	lane_if.mon lanes [evb_pkg::NUM_LANES],
	input evb_pkg::ring_entry_t ring_head_i,
	input logic ring_empty_i,
	input evb_pkg::count_t ring_count_i,
	output logic ring_pop_o,
	output logic [evb_pkg::NUM_LANES-1:0] lane_en_o,
	output logic ovf_clr_o
);
	import evb_pkg::*;

	reg_addr_e addr;
	bus_data_t csr_q;
	bus_data_t rd_val;
	bus_data_t lane_stat [NUM_LANES];
	logic rd_strobe;
	logic csr_wr;

	assign addr = reg_addr_e'(bus_addr_i);
	assign rd_strobe = bus_sel_i && !bus_we_i;
	assign csr_wr = bus_sel_i && bus_we_i && (addr == REG_CSR);

	// Flag on top, fill count below
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_stat
		assign lane_stat[i] = {lanes[i].overflow, 15'b0, lanes[i].count};
	end

	//////////////////////////////
	// Read decode
	//////////////////////////////
	always_comb begin
		rd_val = '0;
		case (addr)
			REG_CSR: rd_val = csr_q;
			REG_LANE0, REG_LANE1, REG_LANE2, REG_LANE3: begin
				rd_val = lane_stat[lane_idx_t'(bus_addr_i - REG_LANE0)];
			end
			REG_RING_STAT: rd_val = bus_data_t'(ring_count_i);
			REG_RING_DATA: begin
				// Bit 31 marks a valid entry
				if (!ring_empty_i) begin
					rd_val = {1'b1, 13'b0, ring_head_i.tag, ring_head_i.word};
				end
			end
			default: rd_val = '0;
		endcase
	end

	// Head leaves the ring at the edge that latches it
	assign ring_pop_o = rd_strobe && (addr == REG_RING_DATA) && !ring_empty_i;

	// Clear pulse, never stored
	assign ovf_clr_o = csr_wr && bus_wdata_i[CSR_CLR_BIT];
	assign lane_en_o = csr_q[CSR_EN_LSB +: NUM_LANES];

	//////////////////////////////
	// CSR and bus response
	//////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			csr_q <= '0;
			bus_ack_o <= 1'b0;
		end else begin
			bus_ack_o <= bus_sel_i;
			if (csr_wr) begin
				csr_q <= bus_wdata_i;
				csr_q[CSR_CLR_BIT] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK125) begin
		if (bus_sel_i) begin
			bus_rdata_o <= rd_val;
		end
	end

endmodule

// File: source/lane_if.sv
`timescale 1ns/10ps

interface lane_if;
	import evb_pkg::*;

	// Head of the lane FIFO
	lane_word_t data;
	logic empty;
	logic pop;

	// Status for the register block
	count_t count;
	logic overflow;

	modport rx (
		output data,
		output empty,
		output count,
		output overflow,
		input pop
	);

	modport arb (
		input data,
		input empty,
		output pop
	);

	modport mon (
		input count,
		input overflow
	);

endinterface

// File: source/lane_rx.sv
`timescale 1ns/10ps

module lane_rx #(
	parameter int LANE_DEPTH = 4
) (
	input logic CLK125,
	input logic rst_i,
	input evb_pkg::lane_word_t link_data_i,
	input logic link_k_i,
	input logic lane_en_i,
	input logic ovf_clr_i,
	lane_if.rx lane
);
	import evb_pkg::*;

	logic push;
	logic fifo_full;

	// K-chars are idles and commas, never payload
	assign push = lane_en_i && !link_k_i;

	sync_fifo #(
		.T (lane_word_t),
		.DEPTH (LANE_DEPTH)
	) rx_fifo (
		.CLK125 (CLK125),
		.rst_i (rst_i),
		.push_i (push),
		.push_data_i (link_data_i),
		.pop_i (lane.pop),
		.head_o (lane.data),
		.empty_o (lane.empty),
		.full_o (fifo_full),
		.count_o (lane.count)
	);

	// Sticky drop flag
	// a drop in the clear cycle still counts
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			lane.overflow <= 1'b0;
		end else if (push && fifo_full) begin
			lane.overflow <= 1'b1;
		end else if (ovf_clr_i) begin
			lane.overflow <= 1'b0;
		end
	end

endmodule

// File: source/ring_arbiter.sv
`timescale 1ns/10ps

module ring_arbiter (
	input logic CLK125,
	input logic rst_i,
	lane_if.arb lanes [evb_pkg::NUM_LANES],
	input logic ring_full_i,
	output logic ring_push_o,
	output evb_pkg::ring_entry_t ring_entry_o
);
	import evb_pkg::*;

	logic [NUM_LANES-1:0] lane_empty;
	lane_word_t lane_data [NUM_LANES];
	lane_idx_t last_q;
	lane_idx_t grant_idx;
	logic grant_vld;

	// Flatten the interface array
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		assign lane_empty[i] = lanes[i].empty;
		assign lane_data[i] = lanes[i].data;
		assign lanes[i].pop = ring_push_o && (grant_idx == lane_idx_t'(i));
	end

	//////////////////////////////
	// Round robin search
	//////////////////////////////
	// Start just after the last winner
	always_comb begin
		lane_idx_t cand;
		cand = last_q;
		grant_vld = 1'b0;
		grant_idx = last_q;
		for (int k = 1; k <= NUM_LANES; k++) begin
			cand = lane_idx_t'(last_q + k);
			if (!grant_vld && !lane_empty[cand]) begin
				grant_vld = 1'b1;
				grant_idx = cand;
			end
		end
	end

	// Nobody wins while the ring is full
	assign ring_push_o = grant_vld && !ring_full_i;
	assign ring_entry_o = {grant_idx, lane_data[grant_idx]};

	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			// Lane 0 goes first after reset
			last_q <= lane_idx_t'(NUM_LANES - 1);
		end else if (ring_push_o) begin
			last_q <= grant_idx;
		end
	end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter type T = logic [15:0],
	parameter int DEPTH = 4
) (
	input logic CLK125,
	input logic rst_i,
	input logic push_i,
	input T push_data_i,
	input logic pop_i,
	output T head_o,
	output logic empty_o,
	output logic full_o,
	output evb_pkg::count_t count_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty_o = (count_o == '0);
	assign full_o = (count_o == DEPTH[15:0]);

	// Drop on full, pop only what is there
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	assign head_o = mem[rd_ptr];

	always_ff @(posedge CLK125) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	//////////////////////////////
	// Pointers and fill count
	//////////////////////////////
	always_ff @(posedge CLK125) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count_o <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count_o <= count_o + 16'(do_push) - 16'(do_pop);
		end
	end

endmodule
